// ==== Makefile ====
TOP = tb_flash_xip

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

obj_dir/V$(TOP): tb.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only -Wall --top-module flash_xip_wb \
		flash_pkg.sv wb_pkg.sv flash_cfg_regs.sv flash_read_seq.sv \
		spi_byte_shifter.sv flash_xip_wb.sv

clean:
	rm -rf obj_dir sim.log

// ==== flash_cfg_regs.sv ====
`timescale 1ns/10ps

module flash_cfg_regs (
    input  logic                   clk,
    input  logic                   resetn,
    input  wb_pkg::wb_req_t        wb_i,
    input  logic                   cfg_stb_i,
    output wb_pkg::wb_rsp_t        cfg_rsp_o,
    input  flash_pkg::flash_pins_t seq_pins_i,
    input  logic [3:0]             io_di_i,
    output flash_pkg::flash_pins_t pins_o,
    output logic                   soft_reset_o
);
    import flash_pkg::*;
    import wb_pkg::*;

    logic        en_q;
    logic        csb_q;
    logic        clk_q;
    logic [3:0]  oe_q;
    logic [3:0]  do_q;
    logic        soft_reset_q;
    logic        cfg_sel;
    logic [3:0]  we;
    flash_pins_t ovr_pins;
    flash_pins_t mux_pins;

    assign cfg_sel = wb_i.cyc && cfg_stb_i;
    assign we      = wb_i.sel & {4{cfg_sel && wb_i.we}};

    always_ff @(posedge clk) begin
        soft_reset_q <= !en_q || (|we); // held while bit-bang mode is on
        if (!resetn) begin
            soft_reset_q <= 1'b1;
            en_q  <= CFG_RESET_VALUE[CFG_EN_BIT];
            csb_q <= CFG_RESET_VALUE[CFG_CSB_BIT];
            clk_q <= CFG_RESET_VALUE[CFG_CLK_BIT];
            oe_q  <= CFG_RESET_VALUE[CFG_OE_LSB +: 4];
            do_q  <= CFG_RESET_VALUE[CFG_DO_LSB +: 4];
        end else begin
            if (we[0]) begin
                csb_q <= wb_i.dat[CFG_CSB_BIT];
                clk_q <= wb_i.dat[CFG_CLK_BIT];
                do_q  <= wb_i.dat[CFG_DO_LSB +: 4];
            end
            if (we[1]) begin
                oe_q <= wb_i.dat[CFG_OE_LSB +: 4];
            end
            if (we[3]) begin
                en_q <= wb_i.dat[CFG_EN_BIT];
            end
        end
    end

    assign soft_reset_o = soft_reset_q;

    assign ovr_pins = '{csb: csb_q, clk: clk_q, io_oe: oe_q, io_do: do_q};
    assign mux_pins = en_q ? seq_pins_i : ovr_pins;

    always_comb begin
        pins_o = mux_pins;
        if (!resetn) begin
            pins_o.io_oe = 4'b0000; // pads released during reset
        end
    end

    always_comb begin
        cfg_rsp_o.dat = '0;
        cfg_rsp_o.dat[CFG_EN_BIT] = en_q;
        cfg_rsp_o.dat[CFG_OE_LSB +: 4] = pins_o.io_oe; // live pin state
        cfg_rsp_o.dat[CFG_CSB_BIT] = pins_o.csb;
        cfg_rsp_o.dat[CFG_CLK_BIT] = pins_o.clk;
        cfg_rsp_o.dat[CFG_DO_LSB +: 4] = io_di_i;
        cfg_rsp_o.ack = cfg_sel;
    end

    bitbang_holds_seq: assert property (@(posedge clk) disable iff (!resetn)
        !en_q |-> soft_reset_o)
        else $error("sequencer not held in reset during bit-bang mode");

endmodule

// ==== flash_pkg.sv ====
package flash_pkg;

    // flash byte address width
    localparam int FLASH_ADDR_W = 24;

    // single-lane commands
    localparam logic [7:0] CMD_READ = 8'h03;
    localparam logic [7:0] CMD_WAKE = 8'hab; // release from power-down

    typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

    // one byte for the shifter
    typedef struct packed {
        logic [7:0] data;
        logic       last; // final byte of a word
        logic [1:0] lane; // byte position in the word
    } byte_req_t;

    // sampled byte, tagged with the lane of its request
    typedef struct packed {
        logic [7:0] data;
        logic [1:0] lane;
    } byte_rsp_t;

    // pad side of the flash port
    typedef struct packed {
        logic       csb;
        logic       clk;
        logic [3:0] io_oe;
        logic [3:0] io_do;
    } flash_pins_t;

endpackage

// ==== flash_read_seq.sv ====
`timescale 1ns/10ps

module flash_read_seq (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 soft_reset_i,
    input  wb_pkg::wb_req_t      wb_i,
    input  logic                 flash_stb_i,
    output wb_pkg::wb_rsp_t      flash_rsp_o,
    output flash_pkg::byte_req_t breq_o,
    output logic                 breq_valid_o,
    input  logic                 breq_ready_i,
    input  flash_pkg::byte_rsp_t brsp_i,
    input  logic                 brsp_done_i,
    output logic                 close_o
);
    import flash_pkg::*;
    import wb_pkg::*;

    typedef enum logic [2:0] {
        S_WAKE,
        S_CMD,
        S_WAIT,
        S_ADDR,
        S_DATA
    } state_t;

    state_t      state_q;
    logic [1:0]  cnt_q;       // address or data byte index
    logic        busy_q;      // byte in flight in the shifter
    logic        last_q;
    logic        close_q;
    logic        first_q;     // first word of this session
    logic        hold_q;      // one word ahead, wait for the master
    logic        valid_q;
    flash_addr_t held_addr_q;
    flash_addr_t fetch_addr_q;
    logic [23:0] asm_q;       // lanes 0 to 2 of the word in progress
    logic [31:0] word_q;

    flash_addr_t req_addr;
    logic        req_act;
    logic        hit;
    logic        jump;
    logic        byte_done;
    logic        word_done;
    logic [31:0] word_next;

    assign req_addr  = {wb_i.adr[FLASH_ADDR_W-1:2], 2'b00};
    assign req_act   = wb_i.cyc && flash_stb_i;
    assign hit       = req_act && valid_q && (req_addr == held_addr_q);
    assign jump      = req_act && !hit && valid_q && (req_addr != fetch_addr_q);
    assign byte_done = busy_q && brsp_done_i;
    assign word_done = byte_done && (state_q == S_DATA) && last_q;
    assign word_next = {brsp_i.data, asm_q};

    assign flash_rsp_o.dat = word_q;
    assign flash_rsp_o.ack = hit;
    assign close_o = close_q;

    always_comb begin
        breq_o = '{data: 8'h00, last: 1'b0, lane: 2'd0};
        breq_valid_o = !busy_q && !close_q;
        case (state_q)
            S_WAKE: breq_o.data = CMD_WAKE;
            S_CMD:  breq_o.data = CMD_READ;
            S_ADDR: begin
                case (cnt_q) // msb first
                    2'd0:    breq_o.data = fetch_addr_q[23:16];
                    2'd1:    breq_o.data = fetch_addr_q[15:8];
                    default: breq_o.data = fetch_addr_q[7:0];
                endcase
            end
            S_DATA: begin
                breq_o.lane = cnt_q;
                breq_o.last = (cnt_q == 2'd3);
                if (cnt_q == 2'd0 && hold_q) begin
                    breq_valid_o = 1'b0; // back-pressure
                end
            end
            default: breq_valid_o = 1'b0; // waiting for a request
        endcase
    end

    always_ff @(posedge clk) begin
        close_q <= 1'b0;
        if (!resetn || soft_reset_i) begin
            state_q <= S_WAKE;
            cnt_q   <= 2'd0;
            busy_q  <= 1'b0;
            close_q <= 1'b1; // abort any open session
            first_q <= 1'b0;
            hold_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (breq_valid_o && breq_ready_i) begin
                busy_q <= 1'b1;
                last_q <= breq_o.last;
            end
            if (byte_done) begin
                busy_q <= 1'b0;
                case (state_q)
                    S_WAKE: begin
                        close_q <= 1'b1;
                        state_q <= S_CMD;
                    end
                    S_CMD:  state_q <= S_WAIT;
                    S_ADDR: begin
                        cnt_q <= cnt_q + 2'd1;
                        if (cnt_q == 2'd2) begin
                            cnt_q   <= 2'd0;
                            state_q <= S_DATA;
                        end
                    end
                    S_DATA: cnt_q <= cnt_q + 2'd1; // wraps after lane 3
                    default: ;
                endcase
            end
            if (state_q == S_WAIT && req_act) begin
                fetch_addr_q <= req_addr;
                first_q <= 1'b1;
                cnt_q   <= 2'd0;
                state_q <= S_ADDR;
            end
            if (word_done) begin
                held_addr_q  <= fetch_addr_q;
                fetch_addr_q <= fetch_addr_q + FLASH_ADDR_W'(WORD_BYTES);
                valid_q <= 1'b1;
                hold_q  <= !first_q;
                first_q <= 1'b0;
            end
            if (req_act) begin
                hold_q <= 1'b0;
            end
            if (jump) begin
                close_q <= 1'b1;
                state_q <= S_CMD;
                cnt_q   <= 2'd0;
                busy_q  <= 1'b0;
                valid_q <= 1'b0;
                hold_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done && state_q == S_DATA) begin
            case (brsp_i.lane)
                2'd0:    asm_q[7:0]   <= brsp_i.data;
                2'd1:    asm_q[15:8]  <= brsp_i.data;
                2'd2:    asm_q[23:16] <= brsp_i.data;
                default: ;
            endcase
        end
        if (word_done) begin
            word_q <= word_next;
        end
    end

    lane_matches_count: assert property (@(posedge clk) disable iff (!resetn)
        (byte_done && state_q == S_DATA) |-> (brsp_i.lane == cnt_q))
        else $error("sampled byte tagged with the wrong lane");

endmodule

// ==== flash_xip_wb.sv ====
`timescale 1ns/10ps

module flash_xip_wb (
    input  logic                   clk,
    input  logic                   resetn,
    input  wb_pkg::wb_req_t        wb_i,
    input  logic                   flash_stb_i,
    input  logic                   cfg_stb_i,
    output wb_pkg::wb_rsp_t        flash_rsp_o,
    output wb_pkg::wb_rsp_t        cfg_rsp_o,
    output flash_pkg::flash_pins_t pins_o,
    input  logic [3:0]             io_di_i
);
    import flash_pkg::*;

    byte_req_t   breq;
    logic        breq_valid;
    logic        breq_ready;
    byte_rsp_t   brsp;
    logic        brsp_done;
    logic        close;
    logic        soft_reset;
    flash_pins_t seq_pins;

    flash_cfg_regs u_cfg (
        .clk          (clk),
        .resetn       (resetn),
        .wb_i         (wb_i),
        .cfg_stb_i    (cfg_stb_i),
        .cfg_rsp_o    (cfg_rsp_o),
        .seq_pins_i   (seq_pins),
        .io_di_i      (io_di_i),
        .pins_o       (pins_o),
        .soft_reset_o (soft_reset)
    );

    flash_read_seq u_seq (
        .clk          (clk),
        .resetn       (resetn),
        .soft_reset_i (soft_reset),
        .wb_i         (wb_i),
        .flash_stb_i  (flash_stb_i),
        .flash_rsp_o  (flash_rsp_o),
        .breq_o       (breq),
        .breq_valid_o (breq_valid),
        .breq_ready_i (breq_ready),
        .brsp_i       (brsp),
        .brsp_done_i  (brsp_done),
        .close_o      (close)
    );

    spi_byte_shifter u_shift (
        .clk          (clk),
        .resetn       (resetn),
        .close_i      (close),
        .breq_i       (breq),
        .breq_valid_i (breq_valid),
        .breq_ready_o (breq_ready),
        .brsp_o       (brsp),
        .brsp_done_o  (brsp_done),
        .io1_di_i     (io_di_i[1]), // flash data out
        .pins_o       (seq_pins)
    );

endmodule

// ==== spi_byte_shifter.sv ====
`timescale 1ns/10ps

module spi_byte_shifter (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   close_i,
    input  flash_pkg::byte_req_t   breq_i,
    input  logic                   breq_valid_i,
    output logic                   breq_ready_o,
    output flash_pkg::byte_rsp_t   brsp_o,
    output logic                   brsp_done_o,
    input  logic                   io1_di_i,
    output flash_pkg::flash_pins_t pins_o
);
    import flash_pkg::*;

    logic       csb_q;
    logic       clk_q;   // spi clock phase
    logic [3:0] cnt_q;   // bits left in this byte
    logic [7:0] obuf_q;
    logic [7:0] ibuf_q;
    logic [1:0] lane_q;
    logic       done_q;

    assign breq_ready_o = (cnt_q == 4'd0);

    always_ff @(posedge clk) begin
        done_q <= 1'b0;
        if (!resetn || close_i) begin
            csb_q <= 1'b1;
            clk_q <= 1'b0;
            cnt_q <= 4'd0;
        end else if (breq_valid_i && breq_ready_o) begin
            csb_q  <= 1'b0; // stays low across bytes
            clk_q  <= 1'b0;
            cnt_q  <= 4'd8;
            obuf_q <= breq_i.data;
            lane_q <= breq_i.lane;
        end else if (cnt_q != 4'd0) begin
            clk_q <= !clk_q;
            if (clk_q) begin
                // falling edge, next bit out
                obuf_q <= {obuf_q[6:0], 1'b0};
                cnt_q  <= cnt_q - 4'd1;
                done_q <= (cnt_q == 4'd1);
            end else begin
                ibuf_q <= {ibuf_q[6:0], io1_di_i}; // sampled at rising edge
            end
        end
    end

    assign brsp_o.data = ibuf_q;
    assign brsp_o.lane = lane_q;
    assign brsp_done_o = done_q;

    assign pins_o.csb   = csb_q;
    assign pins_o.clk   = clk_q;
    assign pins_o.io_oe = {3'b000, !csb_q}; // io0 only
    assign pins_o.io_do = {3'b000, obuf_q[7]};

    done_at_byte_end: assert property (@(posedge clk) disable iff (!resetn)
        brsp_done_o |-> (cnt_q == 4'd0))
        else $error("done pulse with bits still pending");

endmodule

// ==== tb.f ====
flash_pkg.sv
wb_pkg.sv
flash_cfg_regs.sv
flash_read_seq.sv
spi_byte_shifter.sv
flash_xip_wb.sv
tb_flash_model.sv
tb_flash_xip.sv

// ==== tb_flash_model.sv ====
`timescale 1ns/10ps

module tb_flash_model (
    input  flash_pkg::flash_pins_t pins_i,
    input  logic                   bitbang_i,
    output logic [3:0]             io_di_o
);
    import flash_pkg::*;

    int          sessions;
    int          wake_cmds;
    int          read_cmds;
    int          other_cmds;
    int          bit_cnt;    // rising clock edges in this session
    logic        prev_csb;
    logic        prev_sck;
    logic        miso;
    logic [7:0]  shift_in;
    logic [7:0]  cmd;
    logic [7:0]  dout;
    flash_addr_t addr;

    function automatic logic [7:0] byte_at(input flash_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
    endfunction

    assign io_di_o = bitbang_i ? 4'b1010 : {2'b00, miso, 1'b0}; // io1 carries data out

    initial begin
        sessions = 0;
        wake_cmds = 0;
        read_cmds = 0;
        other_cmds = 0;
        bit_cnt = 0;
        prev_csb = 1'b1;
        prev_sck = 1'b0;
        miso = 1'b0;
        shift_in = 8'h00;
        cmd = 8'h00;
        dout = 8'h00;
        addr = '0;
        forever begin
            @(pins_i);
            if (!bitbang_i && prev_csb && !pins_i.csb) begin
                sessions++;
                bit_cnt = 0;
                cmd = 8'h00;
            end else if (!bitbang_i && !pins_i.csb && !prev_sck && pins_i.clk) begin
                shift_in = {shift_in[6:0], pins_i.io_do[0]}; // sampled on rising edge
                bit_cnt++;
                if (bit_cnt == 8) begin
                    cmd = shift_in;
                    case (cmd)
                        CMD_WAKE: wake_cmds++;
                        CMD_READ: read_cmds++;
                        default:  other_cmds++;
                    endcase
                end else if (cmd == CMD_READ && bit_cnt <= 32 && bit_cnt % 8 == 0) begin
                    addr = {addr[15:0], shift_in}; // msb first
                end
            end else if (!bitbang_i && !pins_i.csb && prev_sck && !pins_i.clk) begin
                if (cmd == CMD_READ && bit_cnt >= 32) begin
                    if (bit_cnt % 8 == 0) begin
                        if (bit_cnt > 32) begin
                            addr = addr + 24'd1;
                        end
                        dout = byte_at(addr);
                    end
                    miso = dout[7]; // changes while clk is low
                    dout = {dout[6:0], 1'b0};
                end
            end
            prev_csb = pins_i.csb;
            prev_sck = pins_i.clk;
        end
    end

endmodule

// ==== tb_flash_xip.sv ====
`timescale 1ns/10ps

module tb_flash_xip;
    import flash_pkg::*;
    import wb_pkg::*;

    localparam int          NUM_TESTS   = 5;
    localparam int          WATCHDOG_NS = NUM_TESTS * 20 * 200 * 10; // words x cycles x period
    localparam logic [31:0] SEED        = 32'h9469_beaa;
    localparam logic [31:0] FIRST_ADDR  = 32'h0000_0040;
    localparam logic [31:0] SEQ_BASE    = 32'h0012_3400;
    localparam logic [31:0] RECOV_ADDR  = 32'h0000_a5a4;

    logic        clk;
    logic        resetn;
    wb_req_t     wb_req;
    logic        flash_stb;
    logic        cfg_stb;
    wb_rsp_t     flash_rsp;
    wb_rsp_t     cfg_rsp;
    flash_pins_t pins;
    logic [3:0]  io_di;
    logic        bitbang;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    logic [31:0] last_addr;

    flash_xip_wb uut (
        .clk         (clk),
        .resetn      (resetn),
        .wb_i        (wb_req),
        .flash_stb_i (flash_stb),
        .cfg_stb_i   (cfg_stb),
        .flash_rsp_o (flash_rsp),
        .cfg_rsp_o   (cfg_rsp),
        .pins_o      (pins),
        .io_di_i     (io_di)
    );

    tb_flash_model model (
        .pins_i    (pins),
        .bitbang_i (bitbang),
        .io_di_o   (io_di)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'ha5;
    endfunction

    // lane 0 is the lowest flash address
    function automatic logic [31:0] expected_word(input logic [31:0] adr);
        logic [23:0] base;
        base = {adr[23:2], 2'b00};
        return {flash_byte(base + 24'd3), flash_byte(base + 24'd2),
                flash_byte(base + 24'd1), flash_byte(base)};
    endfunction

    task automatic wait_ack(input logic to_cfg, output logic [31:0] dat);
        wb_rsp_t rsp;
        do begin
            @(negedge clk);
            rsp = to_cfg ? cfg_rsp : flash_rsp;
        end while (!rsp.ack);
        dat = rsp.dat;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we <= 1'b0;
        flash_stb <= 1'b0;
        cfg_stb <= 1'b0;
    endtask

    task automatic wb_read(input logic to_cfg, input logic [31:0] adr, output logic [31:0] dat);
        @(posedge clk);
        wb_req <= '{adr: adr, dat: 32'h0, sel: 4'hf, we: 1'b0, cyc: 1'b1, stb: 1'b1};
        flash_stb <= !to_cfg;
        cfg_stb <= to_cfg;
        wait_ack(to_cfg, dat);
    endtask

    task automatic wb_write(input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] ignored;
        @(posedge clk);
        wb_req <= '{adr: 32'h0, dat: dat, sel: sel, we: 1'b1, cyc: 1'b1, stb: 1'b1};
        cfg_stb <= 1'b1;
        wait_ack(1'b1, ignored);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input flash_pins_t got, input flash_pins_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_first_read();
        int          err0;
        logic [31:0] got;
        err0 = errors;
        wb_read(1'b0, FIRST_ADDR, got);
        check_word("flash_rsp_o.dat", got, expected_word(FIRST_ADDR));
        check_count("wake commands", model.wake_cmds, 1);
        check_count("read commands", model.read_cmds, 1);
        check_count("other commands", model.other_cmds, 0);
        check_count("sessions", model.sessions, 2); // wake, then read
        last_addr = FIRST_ADDR;
        report_test("first_read", err0);
    endtask

    task automatic test_sequential();
        int          err0;
        int          sessions0;
        int          i;
        logic [31:0] adr;
        logic [31:0] got;
        err0 = errors;
        sessions0 = model.sessions;
        for (i = 0; i < 8; i++) begin
            adr = SEQ_BASE + 32'(i * 4);
            wb_read(1'b0, adr, got);
            check_word("flash_rsp_o.dat", got, expected_word(adr));
            last_addr = adr;
        end
        check_count("sessions", model.sessions, sessions0 + 1);
        report_test("sequential", err0);
    endtask

    task automatic test_jumps();
        int          err0;
        int          exp_sessions;
        int          i;
        logic [31:0] adr;
        logic [31:0] got;
        err0 = errors;
        exp_sessions = model.sessions;
        for (i = 0; i < 12; i++) begin
            do begin
                adr = $urandom & 32'h00ff_fffc;
            end while (adr == last_addr);
            if (adr != ((last_addr + 32'd4) & 32'h00ff_ffff)) begin
                exp_sessions++; // not the next word
            end
            wb_read(1'b0, adr, got);
            check_word("flash_rsp_o.dat", got, expected_word(adr));
            last_addr = adr;
        end
        check_count("sessions", model.sessions, exp_sessions);
        report_test("jumps", err0);
    endtask

    task automatic test_cfg_readback();
        int          err0;
        flash_pins_t exp_pins;
        logic [31:0] got;
        err0 = errors;
        exp_pins = '{csb: 1'b0, clk: 1'b1, io_oe: 4'h5, io_do: 4'h3};
        bitbang <= 1'b1;
        wb_write(32'h0000_0513, 4'hf); // en low
        @(negedge clk);
        check_pins("pins_o", pins, exp_pins);
        wb_read(1'b1, 32'h0, got);
        check_word("cfg_rsp_o.dat", got, {20'h0, 4'h5, 2'b00, 1'b0, 1'b1, 4'b1010});
        report_test("cfg_readback", err0);
    endtask

    task automatic test_lanes_recovery();
        int          err0;
        int          wake0;
        int          sessions0;
        flash_pins_t exp_pins;
        logic [31:0] got;
        err0 = errors;
        exp_pins = '{csb: 1'b0, clk: 1'b1, io_oe: 4'hc, io_do: 4'h3};
        wb_write(32'hffff_fcff, 4'b0010);
        @(negedge clk);
        check_pins("pins_o", pins, exp_pins);
        wb_read(1'b1, 32'h0, got);
        check_word("cfg_rsp_o.dat", got, {20'h0, 4'hc, 2'b00, 1'b0, 1'b1, 4'b1010});
        wake0 = model.wake_cmds;
        sessions0 = model.sessions;
        wb_write(32'h8000_0000, 4'b1000); // en high again
        bitbang <= 1'b0;
        wb_read(1'b0, RECOV_ADDR, got);
        check_word("flash_rsp_o.dat", got, expected_word(RECOV_ADDR));
        check_count("wake commands", model.wake_cmds, wake0 + 1);
        check_count("sessions", model.sessions, sessions0 + 2);
        report_test("lanes_recovery", err0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        last_addr = 32'h0;
        resetn <= 1'b0;
        wb_req <= '0;
        flash_stb <= 1'b0;
        cfg_stb <= 1'b0;
        bitbang <= 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        test_first_read();
        test_sequential();
        test_jumps();
        test_cfg_readback();
        test_lanes_recovery();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

    localparam int WORD_BYTES = 4;

    // wishbone classic master side, strobes travel separately
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // configuration register bit map
    localparam int CFG_EN_BIT  = 31;
    localparam int CFG_OE_LSB  = 8;  // 4 bits
    localparam int CFG_CSB_BIT = 5;
    localparam int CFG_CLK_BIT = 4;
    localparam int CFG_DO_LSB  = 0;  // 4 bits, io_di on readback

    // controller enabled, pin overrides all low
    localparam logic [31:0] CFG_RESET_VALUE = 32'h8000_0000;

endpackage
